// ==== verilog/hazard_params.svh ====
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

// Number of queue entries. Must be a power of two.
`define HZ_QUEUE_DEPTH 8

// Occupancy above which the fetch side is stalled.
`define HZ_STALL_LEVEL 4

// addi x0,x0,0 shown in slots that do not issue.
`define HZ_NOP_INSTR 32'h0000_0013

`endif

// ==== verilog/hazard_pkg.sv ====
`include "hazard_params.svh"

package hazard_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [63:0] fetch_word_t;
  typedef logic [4:0] reg_idx_t;

  typedef logic [$clog2(`HZ_QUEUE_DEPTH)-1:0] qptr_t;
  typedef logic [$clog2(`HZ_QUEUE_DEPTH):0] qcount_t; // Holds 0 up to the full depth.

  typedef logic [1:0] issue_cnt_t;

  typedef enum logic [6:0] {
    opcode_lui    = 7'b0110111,
    opcode_auipc  = 7'b0010111,
    opcode_jal    = 7'b1101111,
    opcode_jalr   = 7'b1100111,
    opcode_branch = 7'b1100011,
    opcode_load   = 7'b0000011,
    opcode_store  = 7'b0100011,
    opcode_imm    = 7'b0010011,
    opcode_reg    = 7'b0110011,
    opcode_fence  = 7'b0001111,
    opcode_system = 7'b1110011
  } opcode_e;

endpackage

// ==== verilog/decode_if.sv ====
`timescale 1ns/1ps

interface decode_if
  import hazard_pkg::*;
();

  logic basic;
  logic recognized;
  logic wren;
  logic rden1;
  logic rden2;
  reg_idx_t waddr;
  reg_idx_t raddr1;
  reg_idx_t raddr2;

  modport decoder (
    output basic, recognized, wren, rden1, rden2, waddr, raddr1, raddr2
  );

  modport ctrl (
    input basic, recognized, wren, rden1, rden2, waddr, raddr1, raddr2
  );

endinterface

// ==== verilog/fetch_queue.sv ====
`timescale 1ns/1ps
`include "hazard_params.svh"

module fetch_queue
  import hazard_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic write_en,
  input qptr_t write_ptr,
  input addr_t fetch_pc,
  input fetch_word_t fetch_data,
  input qptr_t read_ptr,
  output addr_t head_pc0,
  output addr_t head_pc1,
  output instr_t head_instr0,
  output instr_t head_instr1
);

  addr_t pc_mem [0:`HZ_QUEUE_DEPTH-1];
  instr_t instr_mem [0:`HZ_QUEUE_DEPTH-1];

  qptr_t write_ptr_1;
  qptr_t rd_ptr [0:1];
  addr_t wr_pc [0:1];
  instr_t wr_instr [0:1];
  addr_t rd_pc [0:1];
  instr_t rd_instr [0:1];

  assign write_ptr_1 = write_ptr + qptr_t'(1); // Wraps with the pointer width.

  assign wr_pc[0] = fetch_pc;
  assign wr_pc[1] = fetch_pc + addr_t'(4);
  assign wr_instr[0] = fetch_data[31:0]; // Lower half is the older instruction.
  assign wr_instr[1] = fetch_data[63:32];

  assign rd_ptr[0] = read_ptr;
  assign rd_ptr[1] = read_ptr + qptr_t'(1);

  always_ff @(posedge clock) begin
    if (reset == 1'b1 && write_en == 1'b1) begin // No writes land while held in reset.
      pc_mem[write_ptr] <= wr_pc[0];
      instr_mem[write_ptr] <= wr_instr[0];
      pc_mem[write_ptr_1] <= wr_pc[1];
      instr_mem[write_ptr_1] <= wr_instr[1];
    end
  end

  // A fetch accepted this cycle is visible at the head right away.
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      rd_pc[k] = pc_mem[rd_ptr[k]];
      rd_instr[k] = instr_mem[rd_ptr[k]];
      if (write_en == 1'b1 && rd_ptr[k] == write_ptr) begin
        rd_pc[k] = wr_pc[0];
        rd_instr[k] = wr_instr[0];
      end else if (write_en == 1'b1 && rd_ptr[k] == write_ptr_1) begin
        rd_pc[k] = wr_pc[1];
        rd_instr[k] = wr_instr[1];
      end
    end
  end

  assign head_pc0 = rd_pc[0];
  assign head_pc1 = rd_pc[1];
  assign head_instr0 = rd_instr[0];
  assign head_instr1 = rd_instr[1];

endmodule

// ==== verilog/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode
  import hazard_pkg::*;
(
  input instr_t instr,
  decode_if.decoder dec
);

  localparam logic [2:0] funct_add = 3'b000;
  localparam logic [2:0] funct_sll = 3'b001;
  localparam logic [2:0] funct_srl = 3'b101;

  opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t rd;

  logic recognized;
  logic basic;
  logic writes_rd;
  logic uses_rs1;
  logic uses_rs2;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd = instr[11:7];

  always_comb begin
    recognized = 1'b1;
    basic = 1'b0;
    writes_rd = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      opcode_lui, opcode_auipc, opcode_jal : begin
        writes_rd = 1'b1;
      end
      opcode_jalr, opcode_load : begin
        writes_rd = 1'b1;
        uses_rs1 = 1'b1;
      end
      opcode_branch, opcode_store : begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      opcode_imm : begin
        writes_rd = 1'b1;
        uses_rs1 = 1'b1;
        case (funct3)
          funct_sll : basic = (funct7 == 7'b0000000);
          funct_srl : basic = (funct7 == 7'b0000000) || (funct7 == 7'b0100000); // srli and srai.
          default : basic = 1'b1;
        endcase
      end
      opcode_reg : begin
        writes_rd = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        if (funct7 == 7'b0000000) begin
          basic = 1'b1;
        end else if (funct7 == 7'b0100000) begin
          basic = (funct3 == funct_add) || (funct3 == funct_srl); // sub and sra.
        end
      end
      opcode_fence : begin
      end
      opcode_system : begin
        if (funct3 != 3'd0 && funct3 != 3'd4) begin
          writes_rd = 1'b1; // CSR access.
        end
        if (funct3 >= 3'd1 && funct3 <= 3'd3) begin
          uses_rs1 = 1'b1; // Register source, not the immediate form.
        end
      end
      default : begin
        recognized = 1'b0;
      end
    endcase
  end

  assign dec.recognized = recognized;
  assign dec.basic = basic;
  assign dec.wren = writes_rd && (rd != '0); // x0 never creates a dependency.
  assign dec.rden1 = uses_rs1;
  assign dec.rden2 = uses_rs2;
  assign dec.waddr = rd;
  assign dec.raddr1 = instr[19:15];
  assign dec.raddr2 = instr[24:20];

endmodule

// ==== verilog/hazard_ctrl.sv ====
`timescale 1ns/1ps
`include "hazard_params.svh"

module hazard_ctrl
  import hazard_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic clear,
  input logic issue_hold,
  decode_if.ctrl slot0,
  decode_if.ctrl slot1,
  output logic write_en,
  output qptr_t write_ptr,
  output qptr_t read_ptr,
  output issue_cnt_t issue_count,
  output logic queue_stall
);

  qcount_t count_reg;
  qcount_t avail;
  qcount_t count_next;
  logic stall_reg;
  logic raw_hazard;
  logic pair_ok;

  assign write_en = fetch_valid && !clear && !stall_reg;

  // Entries visible at the head this cycle, including the new fetch.
  assign avail = write_en ? count_reg + qcount_t'(2) : count_reg;

  assign raw_hazard = slot0.wren &&
                      ((slot1.rden1 && slot1.raddr1 == slot0.waddr) ||
                       (slot1.rden2 && slot1.raddr2 == slot0.waddr));

  assign pair_ok = slot0.recognized && slot1.basic && (avail >= qcount_t'(2)) && !raw_hazard;

  always_comb begin
    if (clear || issue_hold || avail == '0) begin
      issue_count = 2'd0;
    end else if (pair_ok) begin
      issue_count = 2'd2;
    end else begin
      issue_count = 2'd1;
    end
  end

  assign count_next = clear ? '0 : avail - qcount_t'(issue_count);
  assign queue_stall = count_next > qcount_t'(`HZ_STALL_LEVEL);

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      count_reg <= '0;
      write_ptr <= '0;
      read_ptr <= '0;
      stall_reg <= 1'b0;
    end else if (clear == 1'b1) begin
      count_reg <= '0;
      write_ptr <= '0;
      read_ptr <= '0;
      stall_reg <= 1'b0;
    end else begin
      count_reg <= count_next;
      if (write_en == 1'b1) begin
        write_ptr <= write_ptr + qptr_t'(2);
      end
      read_ptr <= read_ptr + qptr_t'(issue_count);
      stall_reg <= queue_stall; // Gates acceptance one cycle later.
    end
  end

endmodule

// ==== verilog/issue_select.sv ====
`timescale 1ns/1ps
`include "hazard_params.svh"

module issue_select
  import hazard_pkg::*;
(
  input issue_cnt_t issue_count,
  input addr_t head_pc0,
  input addr_t head_pc1,
  input instr_t head_instr0,
  input instr_t head_instr1,
  output addr_t pc0,
  output addr_t pc1,
  output addr_t npc0,
  output addr_t npc1,
  output instr_t instr0,
  output instr_t instr1,
  output logic valid0,
  output logic valid1
);

  // Compressed instructions advance by two bytes.
  function automatic addr_t next_pc(input addr_t pc, input instr_t instr);
    addr_t step;
    step = (instr[1:0] == 2'b11) ? addr_t'(4) : addr_t'(2);
    return pc + step;
  endfunction

  assign valid0 = (issue_count != 2'd0);
  assign valid1 = (issue_count == 2'd2);

  assign pc0 = valid0 ? head_pc0 : '0;
  assign pc1 = valid1 ? head_pc1 : '0;
  assign npc0 = valid0 ? next_pc(head_pc0, head_instr0) : '0;
  assign npc1 = valid1 ? next_pc(head_pc1, head_instr1) : '0;
  assign instr0 = valid0 ? head_instr0 : `HZ_NOP_INSTR;
  assign instr1 = valid1 ? head_instr1 : `HZ_NOP_INSTR;

endmodule

// ==== verilog/dual_issue_hazard.sv ====
`timescale 1ns/1ps

module dual_issue_hazard
  import hazard_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input addr_t fetch_pc,
  input fetch_word_t fetch_data,
  input logic clear,
  input logic issue_hold,
  output addr_t pc0,
  output addr_t pc1,
  output addr_t npc0,
  output addr_t npc1,
  output instr_t instr0,
  output instr_t instr1,
  output logic valid0,
  output logic valid1,
  output logic queue_stall
);

  logic write_en;
  qptr_t write_ptr;
  qptr_t read_ptr;
  addr_t head_pc0;
  addr_t head_pc1;
  instr_t head_instr0;
  instr_t head_instr1;
  issue_cnt_t issue_count;

  decode_if slot0_dec ();
  decode_if slot1_dec ();

  fetch_queue u_queue (
    .clock       (clock),
    .reset       (reset),
    .write_en    (write_en),
    .write_ptr   (write_ptr),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .read_ptr    (read_ptr),
    .head_pc0    (head_pc0),
    .head_pc1    (head_pc1),
    .head_instr0 (head_instr0),
    .head_instr1 (head_instr1)
  );

  instr_decode u_decode0 (
    .instr (head_instr0),
    .dec   (slot0_dec.decoder)
  );

  instr_decode u_decode1 (
    .instr (head_instr1),
    .dec   (slot1_dec.decoder)
  );

  hazard_ctrl u_ctrl (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .clear       (clear),
    .issue_hold  (issue_hold),
    .slot0       (slot0_dec.ctrl),
    .slot1       (slot1_dec.ctrl),
    .write_en    (write_en),
    .write_ptr   (write_ptr),
    .read_ptr    (read_ptr),
    .issue_count (issue_count),
    .queue_stall (queue_stall)
  );

  issue_select u_select (
    .issue_count (issue_count),
    .head_pc0    (head_pc0),
    .head_pc1    (head_pc1),
    .head_instr0 (head_instr0),
    .head_instr1 (head_instr1),
    .pc0         (pc0),
    .pc1         (pc1),
    .npc0        (npc0),
    .npc1        (npc1),
    .instr0      (instr0),
    .instr1      (instr1),
    .valid0      (valid0),
    .valid1      (valid1)
  );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clock
);

  localparam realtime half_period = 4.0; // 8 ns period.

  initial clock = 1'b0;

  always #(half_period) clock = ~clock;

endmodule

// ==== sim/dual_issue_hazard_sva.sv ====
`timescale 1ns/1ps
`include "hazard_params.svh"

module dual_issue_hazard_sva
  import hazard_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic issue_hold,
  input qcount_t queue_count,
  input addr_t pc0, pc1, npc0, npc1,
  input instr_t instr0, instr1,
  input logic valid0, valid1, queue_stall,
  input logic exp_valid0, exp_valid1, exp_stall,
  input addr_t exp_pc0, exp_pc1,
  input instr_t exp_instr0, exp_instr1,
  input int exp_count
);

  int fail_count = 0;

  // Full length instructions have both low bits set.
  function automatic addr_t instr_length(input instr_t instr);
    return (instr[1:0] == 2'b11) ? 32'd4 : 32'd2;
  endfunction

  valid0_check: assert property (@(posedge clock) disable iff (!reset) valid0 == exp_valid0)
    else begin
      $error("MISMATCH t=%0t valid0 exp=%0b got=%0b", $time, $sampled(exp_valid0), $sampled(valid0));
      fail_count++;
    end

  valid1_check: assert property (@(posedge clock) disable iff (!reset) valid1 == exp_valid1)
    else begin
      $error("MISMATCH t=%0t valid1 exp=%0b got=%0b", $time, $sampled(exp_valid1), $sampled(valid1));
      fail_count++;
    end

  slot0_check: assert property (@(posedge clock) disable iff (!reset)
                                valid0 |-> pc0 == exp_pc0 && instr0 == exp_instr0)
    else begin
      $error("MISMATCH t=%0t pc0/instr0 exp=%h/%h got=%h/%h", $time, $sampled(exp_pc0),
             $sampled(exp_instr0), $sampled(pc0), $sampled(instr0));
      fail_count++;
    end

  slot1_check: assert property (@(posedge clock) disable iff (!reset)
                                valid1 |-> pc1 == exp_pc1 && instr1 == exp_instr1)
    else begin
      $error("MISMATCH t=%0t pc1/instr1 exp=%h/%h got=%h/%h", $time, $sampled(exp_pc1),
             $sampled(exp_instr1), $sampled(pc1), $sampled(instr1));
      fail_count++;
    end

  npc0_check: assert property (@(posedge clock) disable iff (!reset)
                               valid0 |-> npc0 == exp_pc0 + instr_length(exp_instr0))
    else begin
      $error("MISMATCH t=%0t npc0 exp=%h got=%h", $time,
             $sampled(exp_pc0) + instr_length($sampled(exp_instr0)), $sampled(npc0));
      fail_count++;
    end

  npc1_check: assert property (@(posedge clock) disable iff (!reset)
                               valid1 |-> npc1 == exp_pc1 + instr_length(exp_instr1))
    else begin
      $error("MISMATCH t=%0t npc1 exp=%h got=%h", $time,
             $sampled(exp_pc1) + instr_length($sampled(exp_instr1)), $sampled(npc1));
      fail_count++;
    end

  hold_check: assert property (@(posedge clock) disable iff (!reset)
                               issue_hold |-> !valid0 && !valid1 && pc0 == '0 && pc1 == '0 &&
                               instr0 == `HZ_NOP_INSTR && instr1 == `HZ_NOP_INSTR)
    else begin
      $error("Issue outputs were not masked while issue_hold was high at t=%0t", $time);
      fail_count++;
    end

  stall_check: assert property (@(posedge clock) disable iff (!reset) queue_stall == exp_stall)
    else begin
      $error("MISMATCH t=%0t queue_stall exp=%0b got=%0b", $time, $sampled(exp_stall),
             $sampled(queue_stall));
      fail_count++;
    end

  // A fetch stored while stalled shows up here as one pair too many.
  count_check: assert property (@(posedge clock) disable iff (!reset)
                                int'(queue_count) == exp_count)
    else begin
      $error("MISMATCH t=%0t queue_count exp=%0d got=%0d", $time, $sampled(exp_count),
             $sampled(queue_count));
      fail_count++;
    end

endmodule

// ==== sim/dual_issue_hazard_tb.sv ====
`timescale 1ns/1ps
`include "hazard_params.svh"

module dual_issue_hazard_tb
  import hazard_pkg::*;
();

  // One queued instruction with the decode facts that follow from how it was built.
  typedef struct packed {
    addr_t pc;
    instr_t instr;
    logic recog;
    logic basic;
    logic wr;
    logic use2;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
  } entry_t;

  logic clock;
  logic reset;
  logic fetch_valid;
  addr_t fetch_pc;
  fetch_word_t fetch_data;
  logic clear;
  logic issue_hold;
  addr_t pc0, pc1, npc0, npc1;
  instr_t instr0, instr1;
  logic valid0, valid1, queue_stall;

  entry_t fetch_e0, fetch_e1;
  entry_t model_q[$];
  logic model_stall;
  addr_t next_fetch_pc;
  int timeout_errors = 0;
  int tests_run = 0;

  logic exp_valid0, exp_valid1, exp_stall;
  addr_t exp_pc0, exp_pc1;
  instr_t exp_instr0, exp_instr1;
  int exp_count = 0;

  tb_clock clock_gen (.clock(clock));

  dual_issue_hazard dut0 (.*);

  bind dual_issue_hazard dual_issue_hazard_sva sva0 (
    .*,
    .queue_count (u_ctrl.count_next),
    .exp_valid0 (dual_issue_hazard_tb.exp_valid0),
    .exp_valid1 (dual_issue_hazard_tb.exp_valid1),
    .exp_stall  (dual_issue_hazard_tb.exp_stall),
    .exp_pc0    (dual_issue_hazard_tb.exp_pc0),
    .exp_pc1    (dual_issue_hazard_tb.exp_pc1),
    .exp_instr0 (dual_issue_hazard_tb.exp_instr0),
    .exp_instr1 (dual_issue_hazard_tb.exp_instr1),
    .exp_count  (dual_issue_hazard_tb.exp_count)
  );

  function automatic int total_errors();
    return dut0.sva0.fail_count + timeout_errors;
  endfunction

  function automatic entry_t make_entry(input addr_t pc);
    entry_t e;
    int kind;
    logic [2:0] f3;
    logic [6:0] f7;
    e = '0;
    e.pc = pc;
    e.rd = reg_idx_t'($urandom_range(0, 3)); // Few registers, so dependent pairs are common.
    e.rs1 = reg_idx_t'($urandom_range(0, 3));
    e.rs2 = reg_idx_t'($urandom_range(0, 3));
    f3 = 3'($urandom_range(0, 3) * 2); // addi, slti, xori or ori.
    f7 = ($urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0000000;
    kind = $urandom_range(0, 6);
    e.recog = (kind <= 4);
    e.basic = (kind <= 1);
    e.use2 = (kind == 1);
    e.wr = (kind inside {0, 1, 2, 4}) && (e.rd != '0);
    case (kind)
      0: e.instr = {12'($urandom_range(0, 4095)), e.rs1, f3, e.rd, 7'b0010011};
      1: e.instr = {f7, e.rs2, e.rs1, 3'b000, e.rd, 7'b0110011}; // add or sub.
      2: e.instr = {12'($urandom_range(0, 4095)), e.rs1, 3'b010, e.rd, 7'b0000011};
      3: e.instr = {7'd0, e.rs2, e.rs1, 3'b010, 5'd8, 7'b0100011};
      4: e.instr = {7'b0000001, e.rs2, e.rs1, 3'b000, e.rd, 7'b0110011}; // mul.
      5: e.instr = {7'b0000000, e.rs2, e.rs1, 3'b000, e.rd, 7'b1010011}; // fadd.s
      default: e.instr = {16'($urandom_range(0, 65535)), 16'h4501}; // Short form, low bits 01.
    endcase
    return e;
  endfunction

  function automatic logic pairs_ok(input entry_t a, input entry_t b);
    logic raw;
    raw = a.wr && (b.rs1 == a.rd || (b.use2 && b.rs2 == a.rd)); // Basic ops always read rs1.
    return a.recog && b.basic && !raw;
  endfunction

  // Inputs settle 1 ns after the rising edge, so the model runs on the falling edge.
  always @(negedge clock) begin : ref_model
    int n;
    entry_t h0;
    entry_t h1;
    n = 0;
    h0 = '0;
    h1 = '0;
    if (reset == 1'b0) begin
      model_q.delete();
      model_stall = 1'b0;
    end else begin
      if (fetch_valid && !clear && !model_stall) begin
        model_q.push_back(fetch_e0);
        model_q.push_back(fetch_e1);
      end
      if (model_q.size() > 0) h0 = model_q[0];
      if (model_q.size() > 1) h1 = model_q[1];
      if (clear || issue_hold || model_q.size() == 0) begin
        n = 0;
      end else if (model_q.size() >= 2 && pairs_ok(h0, h1)) begin
        n = 2;
      end else begin
        n = 1;
      end
      if (clear) begin
        model_q.delete();
      end else begin
        repeat (n) void'(model_q.pop_front());
      end
      model_stall = model_q.size() > `HZ_STALL_LEVEL;
    end
    exp_valid0 = (n > 0);
    exp_valid1 = (n == 2);
    exp_pc0 = h0.pc;
    exp_instr0 = h0.instr;
    exp_pc1 = h1.pc;
    exp_instr1 = h1.instr;
    exp_stall = model_stall;
    exp_count = model_q.size();
  end

  task automatic step(input logic valid, input logic hold, input logic clr);
    @(posedge clock);
    #1;
    fetch_e0 = make_entry(next_fetch_pc);
    fetch_e1 = make_entry(next_fetch_pc + 32'd4);
    fetch_pc = next_fetch_pc;
    fetch_data = {fetch_e1.instr, fetch_e0.instr};
    fetch_valid = valid;
    issue_hold = hold;
    clear = clr;
    next_fetch_pc = next_fetch_pc + 32'd8;
  endtask

  task automatic wait_stall(input int limit);
    int cycles;
    cycles = 0;
    while (!queue_stall && cycles < limit) begin
      step(1'b1, 1'b1, 1'b0);
      @(negedge clock);
      cycles++;
    end
    if (!queue_stall) begin
      $display("Timeout: queue_stall did not rise within %0d cycles at t=%0t", limit, $time);
      timeout_errors++;
    end
  endtask

  task automatic wait_empty(input int limit);
    int cycles;
    cycles = 0;
    while (exp_count != 0 && cycles < limit) begin
      step(1'b0, 1'b0, 1'b0);
      cycles++;
    end
    if (exp_count != 0) begin
      $display("Timeout: queue did not drain within %0d cycles at t=%0t", limit, $time);
      timeout_errors++;
    end
  endtask

  task automatic finish_test(input string name, input int start_errors);
    @(posedge clock); // Lets the last cycle's checks fire.
    #1;
    tests_run++;
    $display("test %0s: %0d errors", name, total_errors() - start_errors);
  endtask

  initial begin : main_sequence
    int start;
    void'($urandom(32'hc7eb));
    reset = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_data = '0;
    clear = 1'b0;
    issue_hold = 1'b0;
    fetch_e0 = '0;
    fetch_e1 = '0;
    next_fetch_pc = 32'h0000_1000;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b1;

    start = total_errors();
    repeat (6) step(1'b0, 1'b0, 1'b0);
    finish_test("reset_idle", start);

    start = total_errors();
    repeat (400) begin
      step($urandom_range(0, 3) != 0, $urandom_range(0, 7) == 0, $urandom_range(0, 39) == 0);
    end
    wait_empty(40);
    finish_test("random_stream", start);

    start = total_errors();
    wait_stall(20);
    repeat (4) step(1'b1, 1'b1, 1'b0); // Offered while stalled.
    wait_empty(40);
    finish_test("hold_and_stall", start);

    start = total_errors();
    repeat (2) step(1'b1, 1'b1, 1'b0);
    step(1'b1, 1'b0, 1'b1); // This fetch goes with the clear.
    repeat (4) step(1'b0, 1'b0, 1'b0);
    finish_test("clear_discard", start);

    start = total_errors();
    repeat (2) step(1'b1, 1'b1, 1'b0);
    @(posedge clock);
    #1;
    fetch_valid = 1'b0;
    reset = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b1;
    repeat (4) step(1'b0, 1'b0, 1'b0);
    repeat (20) step(1'b1, 1'b0, 1'b0);
    wait_empty(40);
    finish_test("reset_restart", start);

    $display("tests: %0d, errors: %0d", tests_run, total_errors());
    if (total_errors() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/hazard_pkg.sv
verilog/decode_if.sv
verilog/fetch_queue.sv
verilog/instr_decode.sv
verilog/hazard_ctrl.sv
verilog/issue_select.sv
verilog/dual_issue_hazard.sv
sim/tb_clock.sv
sim/dual_issue_hazard_sva.sv
sim/dual_issue_hazard_tb.sv

// ==== Bender.yml ====
package:
  name: dual_issue_hazard

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/hazard_pkg.sv
      - verilog/decode_if.sv
      - verilog/fetch_queue.sv
      - verilog/instr_decode.sv
      - verilog/hazard_ctrl.sv
      - verilog/issue_select.sv
      - verilog/dual_issue_hazard.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_clock.sv
      - sim/dual_issue_hazard_sva.sv
      - sim/dual_issue_hazard_tb.sv
